// ==== filelist.f ====
rtl/mem_pkg.sv
rtl/cache_ctrl.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/main_memory.sv
rtl/cache_top.sv
tb/cache_tb.sv

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  mem_pkg::mem_input_t        cpu_req_i,
  output mem_pkg::mem_output_t       cpu_rsp_o,
  output mem_pkg::mem_input_t        mem_req_o,
  input  mem_pkg::mem_output_t       mem_rsp_i,
  input  logic                       hit_i,
  input  mem_pkg::cache_entry_t      victim_i,
  input  logic [mem_pkg::DATA_W-1:0] line_data_i,
  output logic                       tag_we_o,
  output logic                       tag_dirty_o,
  output logic                       data_we_o,
  output logic                       data_sel_mem_o
);

  typedef enum logic [1:0] {IDLE, COMP_TAG, ALLOCATE, WRITE_BACK} state_t;

  state_t             state_q;
  state_t             state_d;
  mem_pkg::mem_addr_t victim_addr;
  mem_pkg::mem_addr_t fill_addr;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // The victim line lives at the current index, so only its tag is stored.
  always_comb begin
    victim_addr               = '0;
    victim_addr.fields.tag    = victim_i.tag;
    victim_addr.fields.index  = cpu_req_i.addr.fields.index;
    fill_addr                 = cpu_req_i.addr;
    fill_addr.fields.offset   = '0;
  end

  always_comb begin
    state_d         = state_q;
    cpu_rsp_o.ready = 1'b0;
    cpu_rsp_o.rdata = line_data_i;
    mem_req_o       = '0;
    tag_we_o        = 1'b0;
    tag_dirty_o     = 1'b0;
    data_we_o       = 1'b0;
    data_sel_mem_o  = 1'b0;

    case (state_q)
      IDLE: begin
        if (cpu_req_i.valid) begin
          state_d = COMP_TAG;
        end
      end

      COMP_TAG: begin
        if (!cpu_req_i.valid) begin
          state_d = IDLE;
        end else if (hit_i) begin
          cpu_rsp_o.ready = 1'b1;
          state_d         = IDLE;
          if (cpu_req_i.write) begin
            tag_we_o    = 1'b1; // Rewrites the same tag with dirty set.
            tag_dirty_o = 1'b1;
            data_we_o   = 1'b1;
          end
        end else if (victim_i.valid && victim_i.dirty) begin
          state_d = WRITE_BACK;
        end else begin
          state_d = ALLOCATE;
        end
      end

      WRITE_BACK: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.write = 1'b1;
        mem_req_o.addr  = victim_addr;
        mem_req_o.wdata = line_data_i;
        if (mem_rsp_i.ready) begin
          state_d = ALLOCATE;
        end
      end

      ALLOCATE: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.addr  = fill_addr;
        if (mem_rsp_i.ready) begin
          tag_we_o       = 1'b1; // The fill arrives clean.
          data_we_o      = 1'b1;
          data_sel_mem_o = 1'b1;
          state_d        = COMP_TAG;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Ready answers only a live request whose stored line is valid and carries its tag.
  a_cpu_ready_on_hit: assert property (@(posedge clk_i) disable iff (reset_i)
    cpu_rsp_o.ready |-> (state_q == COMP_TAG) && cpu_req_i.valid && victim_i.valid &&
                        (victim_i.tag == cpu_req_i.addr.fields.tag));

  // No memory transfer is open while the FSM waits in IDLE.
  a_no_mem_req_in_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == IDLE) |-> !mem_req_o.valid && !mem_rsp_i.ready);

endmodule

// ==== rtl/cache_data_array.sv ====
`timescale 1ns/1ps

module cache_data_array (
  input  logic                       clk_i,
  input  mem_pkg::mem_addr_t         addr_i,
  input  logic                       we_i,
  input  logic                       sel_mem_i,
  input  logic [mem_pkg::DATA_W-1:0] cpu_wdata_i,
  input  logic [mem_pkg::DATA_W-1:0] mem_rdata_i,
  output logic [mem_pkg::DATA_W-1:0] data_o
);

  logic [mem_pkg::DATA_W-1:0] words_q [mem_pkg::CACHE_LINES];
  logic [mem_pkg::DATA_W-1:0] wdata;

  // A fill takes the memory word, a write hit takes the processor word.
  assign wdata = sel_mem_i ? mem_rdata_i : cpu_wdata_i;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      words_q[addr_i.fields.index] <= wdata;
    end
  end

  assign data_o = words_q[addr_i.fields.index];

endmodule

// ==== rtl/cache_tag_array.sv ====
`timescale 1ns/1ps

module cache_tag_array (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mem_pkg::mem_addr_t    addr_i,
  input  logic                  we_i,
  input  logic                  dirty_i,
  output mem_pkg::cache_entry_t entry_o,
  output logic                  hit_o
);

  mem_pkg::cache_entry_t [mem_pkg::CACHE_LINES-1:0] lines_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mem_pkg::CACHE_LINES; i++) begin
        lines_q[i].valid <= 1'b0; // Tags and dirty bits are don't-care once invalid.
      end
    end else if (we_i) begin
      lines_q[addr_i.fields.index] <= '{
        valid: 1'b1,
        dirty: dirty_i,
        tag:   addr_i.fields.tag
      };
    end
  end

  assign entry_o = lines_q[addr_i.fields.index];
  assign hit_o   = entry_o.valid && (entry_o.tag == addr_i.fields.tag);

  // The controller sits in IDLE through reset, so no line is written then.
  a_no_write_in_reset: assert property (@(posedge clk_i)
    we_i |-> !reset_i);

endmodule

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  mem_pkg::mem_input_t  cpu_req_i,
  output mem_pkg::mem_output_t cpu_rsp_o
);

  mem_pkg::mem_input_t        mem_req;
  mem_pkg::mem_output_t       mem_rsp;
  mem_pkg::cache_entry_t      victim;
  logic                       hit;
  logic [mem_pkg::DATA_W-1:0] line_data;
  logic                       tag_we;
  logic                       tag_dirty;
  logic                       data_we;
  logic                       data_sel_mem;

  cache_ctrl u_cache_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cpu_req_i      (cpu_req_i),
    .cpu_rsp_o      (cpu_rsp_o),
    .mem_req_o      (mem_req),
    .mem_rsp_i      (mem_rsp),
    .hit_i          (hit),
    .victim_i       (victim),
    .line_data_i    (line_data),
    .tag_we_o       (tag_we),
    .tag_dirty_o    (tag_dirty),
    .data_we_o      (data_we),
    .data_sel_mem_o (data_sel_mem)
  );

  cache_tag_array u_cache_tag_array (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .addr_i  (cpu_req_i.addr),
    .we_i    (tag_we),
    .dirty_i (tag_dirty),
    .entry_o (victim),
    .hit_o   (hit)
  );

  cache_data_array u_cache_data_array (
    .clk_i       (clk_i),
    .addr_i      (cpu_req_i.addr),
    .we_i        (data_we),
    .sel_mem_i   (data_sel_mem),
    .cpu_wdata_i (cpu_req_i.wdata),
    .mem_rdata_i (mem_rsp.rdata),
    .data_o      (line_data)
  );

  main_memory u_main_memory (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (mem_req),
    .rsp_o   (mem_rsp)
  );

endmodule

// ==== rtl/main_memory.sv ====
`timescale 1ns/1ps

module main_memory (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  mem_pkg::mem_input_t  req_i,
  output mem_pkg::mem_output_t rsp_o
);

  logic [mem_pkg::DATA_W-1:0]     mem_q [mem_pkg::MEM_WORDS];
  logic                           busy_q;
  logic [mem_pkg::MEM_CNT_W-1:0]  cnt_q;
  logic                           ready_q;
  logic [mem_pkg::DATA_W-1:0]     rdata_q;
  logic [mem_pkg::MEM_ADDR_W-1:0] word_addr;
  logic                           last_cycle;

  assign word_addr  = req_i.addr.raw[mem_pkg::OFFSET_W +: mem_pkg::MEM_ADDR_W];
  assign last_cycle = busy_q && (cnt_q == mem_pkg::MEM_LAST_CNT);

  // The ready cycle itself does not start a request, since the requester still holds it.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      cnt_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= last_cycle;
      if (last_cycle) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (req_i.valid && !ready_q) begin
        busy_q <= 1'b1;
        cnt_q  <= mem_pkg::MEM_CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (last_cycle) begin
      if (req_i.write) begin
        mem_q[word_addr] <= req_i.wdata;
      end
      rdata_q <= mem_q[word_addr];
    end
  end

  assign rsp_o = '{ready: ready_q, rdata: rdata_q};

  a_addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (busy_q || ready_q) |-> $stable(req_i.addr.raw));

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

  localparam int ADDR_W           = 32;
  localparam int DATA_W           = 32;
  localparam int CACHE_INDEX_SIZE = 4;
  localparam int CACHE_LINES      = 2 ** CACHE_INDEX_SIZE;
  localparam int OFFSET_W         = 2;
  localparam int TAG_W            = ADDR_W - CACHE_INDEX_SIZE - OFFSET_W;

  localparam int MEM_WORDS   = 256;
  localparam int MEM_ADDR_W  = $clog2(MEM_WORDS);
  localparam int MEM_LATENCY = 3;
  localparam int MEM_CNT_W   = $clog2(MEM_LATENCY);
  // Counter value in the cycle before the memory raises ready.
  localparam logic [MEM_CNT_W-1:0] MEM_LAST_CNT = MEM_CNT_W'(MEM_LATENCY - 1);

  typedef struct packed {
    logic [TAG_W-1:0]            tag;
    logic [CACHE_INDEX_SIZE-1:0] index;
    logic [OFFSET_W-1:0]         offset;
  } addr_fields_t;

  // The same address word, seen flat or split for the cache lookup.
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    addr_fields_t      fields;
  } mem_addr_t;

  typedef struct packed {
    logic              valid;
    logic              write;
    mem_addr_t         addr;
    logic [DATA_W-1:0] wdata;
  } mem_input_t;

  typedef struct packed {
    logic              ready; // One-cycle strobe.
    logic [DATA_W-1:0] rdata;
  } mem_output_t;

  typedef struct packed {
    logic             valid;
    logic             dirty;
    logic [TAG_W-1:0] tag;
  } cache_entry_t;

endpackage

// ==== tb/cache_patterns.mem ====
// Columns: op, address, write data, expected read data (all hex).
// Op 0 read hit, 1 write hit, 2 read miss, 3 write miss, 4 reset with the other columns unused.
3 00000004 a5a50001 00000000
0 00000004 00000000 a5a50001
0 00000004 00000000 a5a50001
1 00000004 a5a50002 00000000
0 00000004 00000000 a5a50002
// Same index as 0x004, so the dirty line goes back to memory first.
3 00000044 b6b60001 00000000
2 00000004 00000000 a5a50002
2 00000044 00000000 b6b60001
0 00000044 00000000 b6b60001
2 00000004 00000000 a5a50002
2 00000044 00000000 b6b60001
2 00000004 00000000 a5a50002
2 00000044 00000000 b6b60001
0 00000044 00000000 b6b60001
3 00000010 c3c30001 00000000
3 00000050 d4d40001 00000000
3 00000084 e5e50001 00000000
0 00000050 00000000 d4d40001
0 00000084 00000000 e5e50001
1 00000084 e5e50002 00000000
2 00000004 00000000 a5a50002
3 000003fc f0f00001 00000000
3 0000003c 0f0f0001 00000000
2 000003fc 00000000 f0f00001
0 000003fc 00000000 f0f00001
1 00000050 d4d40002 00000000
// Only words that were written back survive the reset.
4 00000000 00000000 00000000
2 00000084 00000000 e5e50002
0 00000084 00000000 e5e50002
2 00000010 00000000 c3c30001
2 0000003c 00000000 0f0f0001
2 000003fc 00000000 f0f00001
0 00000010 00000000 c3c30001

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

  localparam int NUM_OPS      = 33;
  localparam int WORDS_PER_OP = 4;
  localparam int HIT_CYCLES   = 2;
  localparam int MISS_MIN     = mem_pkg::MEM_LATENCY + 2;
  localparam int TIMEOUT      = 50;
  localparam int RESET_CYCLES = 4;

  logic                 clk_i;
  logic                 reset_i;
  mem_pkg::mem_input_t  cpu_req;
  mem_pkg::mem_output_t cpu_rsp;

  logic [31:0] patterns [NUM_OPS * WORDS_PER_OP];

  cache_top u_cache_top (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp)
  );

  always #4 clk_i = ~clk_i; // 8 ns period.

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // Main memory keeps its contents, only the cache state is cleared.
  task automatic apply_reset();
    @(posedge clk_i);
    reset_i <= 1'b1;
    cpu_req <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
  endtask

  task automatic run_op(input int n);
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] expected;
    logic [31:0] rdata;
    logic        got_ready;
    int          cycles;
    op       = patterns[n * WORDS_PER_OP];
    addr     = patterns[n * WORDS_PER_OP + 1];
    wdata    = patterns[n * WORDS_PER_OP + 2];
    expected = patterns[n * WORDS_PER_OP + 3];
    assert (op <= 32'h4) else
      report_error($sformatf("operation %0d has an unknown op code %h", n, op));
    if (op == 32'h4) begin
      apply_reset();
    end else begin
      @(posedge clk_i);
      assert (!cpu_rsp.ready) else
        report_error($sformatf("mismatch at %0t: ready held past one cycle before op %0d",
                               $time, n));
      cpu_req.valid    <= 1'b1;
      cpu_req.write    <= op[0];
      cpu_req.addr.raw <= addr;
      cpu_req.wdata    <= wdata;

      // Cycles are counted from the edge that presents the request.
      cycles    = 0;
      got_ready = 1'b0;
      rdata     = '0;
      while (!got_ready && cycles < TIMEOUT) begin
        @(posedge clk_i);
        cycles++;
        got_ready = cpu_rsp.ready;
        rdata     = cpu_rsp.rdata;
      end
      cpu_req.valid <= 1'b0;

      assert (got_ready) else
        report_error($sformatf("ready never came for operation %0d at address %h in %0d cycles",
                               n, addr, TIMEOUT));
      if (op[1]) begin
        assert (cycles >= MISS_MIN) else
          report_error($sformatf("mismatch at %0t: op %0d miss took %0d cycles, expected >= %0d",
                                 $time, n, cycles, MISS_MIN));
      end else begin
        assert (cycles == HIT_CYCLES) else
          report_error($sformatf("mismatch at %0t: op %0d hit took %0d cycles, expected %0d",
                                 $time, n, cycles, HIT_CYCLES));
      end
      if (!op[0]) begin
        assert (rdata === expected) else
          report_error($sformatf("mismatch at %0t: op %0d read %h from address %h, expected %h",
                                 $time, n, rdata, addr, expected));
      end
    end
  endtask

  initial begin
    clk_i   = 1'b0;
    reset_i = 1'b1;
    cpu_req = '0;
    $readmemh("tb/cache_patterns.mem", patterns);

    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;

    for (int n = 0; n < NUM_OPS; n++) begin
      run_op(n);
    end
    @(posedge clk_i);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
